//--- verilog/conPkg.sv
package conPkg;

  // Fields use DEC bit numbering, so bit 0 is the most significant
  typedef logic [0:5]  condField_t;
  typedef logic [0:8]  magicField_t;
  typedef logic [0:3]  memField_t;
  typedef logic [0:35] ebusWord_t;

  // One enable per condition group, bit 0 is group 0x
  typedef logic [0:7] condGroup_t;

  // Microcode state 1, 3, 5 and 7 in bits 0 to 3
  typedef logic [0:3] ucodeState_t;

  typedef logic [0:3] srValue_t;

  // Console functions as seen on the diagnostic select lines
  typedef enum logic [2:0] {
    DIAG_CLR_RUN     = 3'd0,
    DIAG_SET_RUN     = 3'd1,
    DIAG_CONTINUE    = 3'd2,
    DIAG_IR_STROBE   = 3'd4,
    DIAG_DRAM_STROBE = 3'd5
  } diagFunc_e;

  // Subfunctions of magic 01x, taken from magic bits 6 to 8
  typedef enum logic [2:0] {
    IO_CONO_APR  = 3'd4,
    IO_CONO_PI   = 3'd5,
    IO_CONO_PAG  = 3'd6,
    IO_DATAO_APR = 3'd7
  } ioFunc_e;

  // Group 1x items
  localparam logic [2:0] COND_LOAD_IR    = 3'd4;
  localparam logic [2:0] COND_SPEC_INSTR = 3'd5;
  localparam logic [2:0] COND_SR_MAGIC   = 3'd6;

  // Group 2x items
  localparam logic [2:0] COND_DIAG_FUNC  = 3'd0;
  localparam logic [2:0] COND_EBOX_STATE = 3'd1;

  // Magic bits 3 to 5 for the 01x family
  localparam logic [2:0] FUNC_01X = 3'd1;

endpackage

//--- verilog/condDecoder.sv
`timescale 1ns/10ps

module condDecoder import conPkg::*; (
  input  logic       arstN,
  input  condField_t cond,
  output condGroup_t condEn,
  output logic       loadIrCond,
  output logic       specInstrCond,
  output logic       srMagicCond,
  output logic       diagFuncCond,
  output logic       ebusStateCond
);

  logic [2:0] groupSel;
  logic [2:0] itemSel;
  logic       group1x;
  logic       group2x;

  assign groupSel = cond[0:2];
  assign itemSel  = cond[3:5];

  // First level, blanked while the board is held in reset
  always_comb begin
    condEn = '0;
    if (arstN) begin
      condEn[groupSel] = 1'b1;
    end
  end

  assign group1x = condEn[1];
  assign group2x = condEn[2];

  // Second level for the groups this board acts on
  assign loadIrCond    = group1x && (itemSel == COND_LOAD_IR);
  assign specInstrCond = group1x && (itemSel == COND_SPEC_INSTR);
  assign srMagicCond   = group1x && (itemSel == COND_SR_MAGIC);

  assign diagFuncCond  = group2x && (itemSel == COND_DIAG_FUNC);
  assign ebusStateCond = group2x && (itemSel == COND_EBOX_STATE);

endmodule

//--- verilog/consoleRunCtl.sv
`timescale 1ns/10ps

module consoleRunCtl import conPkg::*; #(
  parameter int RunSyncStages = 3
) (
  input  logic      CON_CLK,
  input  logic      arstN,
  input  logic      diagCtlEn,
  input  diagFunc_e diagSel,
  output logic      run,
  output logic      start,
  output logic      diagIrStrobe
);

  logic runReg;
  logic contReq;
  logic contDelayed;
  logic contPrev;
  // Bit 1 carries run, bit 0 the continue request
  logic [RunSyncStages-1:0][1:0] syncChain;

  // Console requests, taken on every edge with the strobe up
  always_ff @(posedge CON_CLK or negedge arstN) begin
    if (!arstN) begin
      runReg  <= 1'b0;
      contReq <= 1'b0;
    end else begin
      contReq <= diagCtlEn && (diagSel == DIAG_CONTINUE);
      if (diagCtlEn && (diagSel == DIAG_SET_RUN)) begin
        runReg <= 1'b1;
      end else if (diagCtlEn && (diagSel == DIAG_CLR_RUN)) begin
        runReg <= 1'b0;
      end
    end
  end

  always_ff @(posedge CON_CLK or negedge arstN) begin
    if (!arstN) begin
      syncChain <= '0;
      contPrev  <= 1'b0;
    end else begin
      syncChain[0] <= {runReg, contReq};
      for (int i = 1; i < RunSyncStages; i++) begin
        syncChain[i] <= syncChain[i-1];
      end
      contPrev <= contDelayed;
    end
  end

  assign run         = syncChain[RunSyncStages-1][1];
  assign contDelayed = syncChain[RunSyncStages-1][0];

  // One start pulse per continue, even when the strobe is held
  assign start = contDelayed && !contPrev;

  assign diagIrStrobe = diagCtlEn && (diagSel == DIAG_IR_STROBE);

endmodule

//--- verilog/ioFuncDecoder.sv
`timescale 1ns/10ps

module ioFuncDecoder import conPkg::*; (
  input  logic        CON_CLK,
  input  logic        arstN,
  input  logic        diagFuncCond,
  input  magicField_t magic,
  input  ebusWord_t   ebusData,
  input  logic        ebusSync,
  output logic        conoApr,
  output logic        conoPi,
  output logic        conoPag,
  output logic        dataoApr,
  output logic        conoApr200000,
  output logic        selEn,
  output logic        selDis,
  output logic        selClr,
  output logic        selSet,
  output logic        delayReq,
  output logic        cacheLookEn,
  output logic        cacheLoadEn,
  output logic        klPagingEn,
  output logic        trapEn,
  output logic        wrEvenParAdr,
  output logic        wrEvenParData,
  output logic        wrEvenParDir
);

  logic       func01x;
  logic [2:0] subFunc;

  assign func01x = diagFuncCond && !magic[2] && (magic[3:5] == FUNC_01X);
  assign subFunc = magic[6:8];

  // APR and PI functions only fire in step with the EBOX
  assign conoApr  = func01x && (subFunc == IO_CONO_APR) && ebusSync;
  assign conoPi   = func01x && (subFunc == IO_CONO_PI) && ebusSync;
  assign conoPag  = func01x && (subFunc == IO_CONO_PAG);
  assign dataoApr = func01x && (subFunc == IO_DATAO_APR);

  assign selEn  = ebusData[20] && conoApr;
  assign selDis = ebusData[21] && conoApr;
  assign selClr = ebusData[22] && conoApr;
  assign selSet = ebusData[23] && conoApr;

  assign delayReq = diagFuncCond && magic[3];

  always_ff @(posedge CON_CLK or negedge arstN) begin
    if (!arstN) begin
      cacheLookEn   <= 1'b0;
      cacheLoadEn   <= 1'b0;
      klPagingEn    <= 1'b0;
      trapEn        <= 1'b0;
      wrEvenParAdr  <= 1'b0;
      wrEvenParData <= 1'b0;
      wrEvenParDir  <= 1'b0;
      conoApr200000 <= 1'b0;
    end else begin
      if (conoPag) begin
        cacheLookEn <= ebusData[18];
        cacheLoadEn <= ebusData[19];
        klPagingEn  <= ebusData[21];
        trapEn      <= ebusData[22];
      end
      // Even parity write controls for diagnostics
      if (conoPi) begin
        wrEvenParAdr  <= ebusData[18];
        wrEvenParData <= ebusData[19];
        wrEvenParDir  <= ebusData[20];
      end
      conoApr200000 <= conoApr && ebusData[19];
    end
  end

endmodule

//--- verilog/specInstrState.sv
`timescale 1ns/10ps

module specInstrState import conPkg::*; (
  input  logic        CON_CLK,
  input  logic        arstN,
  input  magicField_t magic,
  input  logic        dispNicond,
  input  logic        specInstrCond,
  input  logic        srMagicCond,
  input  logic        ebusStateCond,
  input  logic        run,
  output logic        kernelCycle,
  output logic        pcPlus1Inh,
  output logic        pxct,
  output logic        intDisable,
  output logic        eboxHalted,
  output logic        piDisable,
  output srValue_t    sr,
  output ucodeState_t ucodeState
);

  logic loadSpecInstr;

  // NICOND dispatch reloads the flags as well
  assign loadSpecInstr = dispNicond || specInstrCond;

  always_ff @(posedge CON_CLK or negedge arstN) begin
    if (!arstN) begin
      kernelCycle <= 1'b0;
      pcPlus1Inh  <= 1'b0;
      pxct        <= 1'b0;
      intDisable  <= 1'b0;
      eboxHalted  <= 1'b0;
    end else if (loadSpecInstr) begin
      kernelCycle <= magic[1];
      pcPlus1Inh  <= magic[2];
      pxct        <= magic[4];
      intDisable  <= magic[5];
      eboxHalted  <= magic[7];
    end
  end

  always_ff @(posedge CON_CLK or negedge arstN) begin
    if (!arstN) begin
      sr <= '0;
    end else if (srMagicCond) begin
      sr <= magic[5:8];
    end
  end

  // Odd magic bit sets the state, the even bit after it holds it
  always_ff @(posedge CON_CLK or negedge arstN) begin
    if (!arstN) begin
      ucodeState <= '0;
    end else if (ebusStateCond) begin
      for (int k = 0; k < 4; k++) begin
        ucodeState[k] <= magic[2*k+1] || (magic[2*k+2] && ucodeState[k]);
      end
    end
  end

  assign piDisable = !run || eboxHalted;

endmodule

//--- verilog/cycleTracker.sv
`timescale 1ns/10ps

module cycleTracker import conPkg::*; (
  input  logic        CON_CLK,
  input  logic        arstN,
  input  memField_t   mem,
  input  magicField_t magic,
  input  logic        specInstrCond,
  input  logic        loadIrCond,
  input  logic        diagIrStrobe,
  input  logic        mboxCycReq,
  input  logic        vmaFetch,
  input  logic        vmaAcRef,
  input  logic        mbXfer,
  input  logic        pageError,
  input  logic        skipSatisfied,
  input  logic        saveFlags,
  input  logic        specFlagCtl,
  input  logic        ebusSync,
  output logic        memCycle,
  output logic        piCycle,
  output logic        mboxWait,
  output logic        fmXfer,
  output logic        loadIr
);

  logic xfer;
  logic piCycleClr;

  assign mboxWait = mem[2] && memCycle;
  // AC references are served from fast memory
  assign fmXfer   = mboxWait && vmaAcRef;
  assign xfer     = fmXfer || mbXfer;

  assign piCycleClr = (saveFlags && piCycle && ebusSync) || (specFlagCtl && magic[2]);

  // A new request wins over the end of the previous cycle
  always_ff @(posedge CON_CLK or negedge arstN) begin
    if (!arstN) begin
      memCycle <= 1'b0;
    end else if (mboxCycReq) begin
      memCycle <= 1'b1;
    end else if (xfer || pageError) begin
      memCycle <= 1'b0;
    end
  end

  always_ff @(posedge CON_CLK or negedge arstN) begin
    if (!arstN) begin
      piCycle <= 1'b0;
    end else if (specInstrCond && magic[0]) begin
      piCycle <= 1'b1;
    end else if (skipSatisfied || piCycleClr) begin
      piCycle <= 1'b0;
    end
  end

  assign loadIr = (vmaFetch && memCycle) || loadIrCond || diagIrStrobe;

endmodule

//--- verilog/conTop.sv
`timescale 1ns/10ps

module conTop import conPkg::*; #(
  parameter int RunSyncStages = 3
) (
  input  logic        CON_CLK,
  input  logic        arstN,
  input  condField_t  cond,
  input  magicField_t magic,
  input  memField_t   mem,
  input  logic        diagCtlEn,
  input  diagFunc_e   diagSel,
  input  ebusWord_t   ebusData,
  input  logic        ebusSync,
  input  logic        dispNicond,
  input  logic        mboxCycReq,
  input  logic        vmaFetch,
  input  logic        vmaAcRef,
  input  logic        mbXfer,
  input  logic        pageError,
  input  logic        skipSatisfied,
  input  logic        saveFlags,
  input  logic        specFlagCtl,
  output condGroup_t  condEn,
  output logic        run,
  output logic        start,
  output logic        conoApr,
  output logic        conoPi,
  output logic        conoPag,
  output logic        dataoApr,
  output logic        conoApr200000,
  output logic        selEn,
  output logic        selDis,
  output logic        selClr,
  output logic        selSet,
  output logic        delayReq,
  output logic        cacheLookEn,
  output logic        cacheLoadEn,
  output logic        klPagingEn,
  output logic        trapEn,
  output logic        wrEvenParAdr,
  output logic        wrEvenParData,
  output logic        wrEvenParDir,
  output logic        kernelCycle,
  output logic        pcPlus1Inh,
  output logic        pxct,
  output logic        intDisable,
  output logic        eboxHalted,
  output logic        piDisable,
  output srValue_t    sr,
  output ucodeState_t ucodeState,
  output logic        memCycle,
  output logic        piCycle,
  output logic        mboxWait,
  output logic        fmXfer,
  output logic        loadIr
);

  // Item strobes from the condition decode
  logic loadIrCond;
  logic specInstrCond;
  logic srMagicCond;
  logic diagFuncCond;
  logic ebusStateCond;

  logic diagIrStrobe;

  condDecoder i_condDecoder (.*);

  consoleRunCtl #(
    .RunSyncStages(RunSyncStages)
  ) i_consoleRunCtl (.*);

  ioFuncDecoder i_ioFuncDecoder (.*);

  specInstrState i_specInstrState (.*);

  cycleTracker i_cycleTracker (.*);

endmodule

//--- test/conTop_properties.sv
`timescale 1ns/10ps

module conTopProperties import conPkg::*; (
  input logic       CON_CLK,
  input logic       arstN,
  input condGroup_t condEn,
  input logic       conoApr,
  input logic       conoPi,
  input logic       conoPag,
  input logic       dataoApr,
  input logic       start
);

  int failCount = 0;

  // Holds in reset too, where condEn is blank
  condOneHot: assert property (@(posedge CON_CLK) $onehot0(condEn))
    else begin
      $error("condEn has more than one group enable set");
      failCount++;
    end

  ioExclusive: assert property (@(posedge CON_CLK) disable iff (!arstN)
    $onehot0({conoApr, conoPi, conoPag, dataoApr}))
    else begin
      $error("More than one I/O function strobe active");
      failCount++;
    end

  startSingle: assert property (@(posedge CON_CLK) disable iff (!arstN) start |=> !start)
    else begin
      $error("start held high for two cycles");
      failCount++;
    end

endmodule

bind conTop conTopProperties i_conTopProperties (.*);

//--- include/conTbTasks.svh
`ifndef CON_TB_TASKS_SVH
`define CON_TB_TASKS_SVH

function automatic logic [31:0] nextRandom();
  logic [31:0] x;
  x = rngState;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rngState = x;
  return x;
endfunction

function automatic ebusWord_t randomEbusWord();
  logic [63:0] wide;
  wide = {nextRandom(), nextRandom()};
  return wide[35:0];
endfunction

function automatic logic sampleSignal(input string name);
  if (name == "run") begin
    return run;
  end else begin
    return start;
  end
endfunction

task automatic checkBit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
    errorCount++;
  end
endtask

task automatic checkCondGroup(input string name, input condGroup_t got, input condGroup_t exp);
  if (got !== exp) begin
    $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
    errorCount++;
  end
endtask

task automatic checkSr(input string name, input srValue_t got, input srValue_t exp);
  if (got !== exp) begin
    $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
    errorCount++;
  end
endtask

task automatic checkUcodeState(input string name, input ucodeState_t got,
                               input ucodeState_t exp);
  if (got !== exp) begin
    $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
    errorCount++;
  end
endtask

task automatic checkLatency(input string name, input int got, input int exp);
  if (got != exp) begin
    $display("[ERROR] %0t %s latency: got %0d, expected %0d", $time, name, got, exp);
    errorCount++;
  end
endtask

// Counts edges until the level shows at the following negedge
task automatic waitForLevel(input string name, input logic level, output int cycles);
  cycles = 0;
  while (cycles < WaitLimit) begin
    @(posedge CON_CLK);
    cycles++;
    @(negedge CON_CLK);
    if (sampleSignal(name) === level) begin
      return;
    end
  end
  $display("Timeout: %s did not go to %b within %0d cycles", name, level, WaitLimit);
  timeoutCount++;
endtask

task automatic checkRegsCleared();
  checkBit("run", run, 1'b0);
  checkBit("start", start, 1'b0);
  checkBit("memCycle", memCycle, 1'b0);
  checkBit("piCycle", piCycle, 1'b0);
  checkBit("config registers", |{cacheLookEn, cacheLoadEn, klPagingEn, trapEn,
           wrEvenParAdr, wrEvenParData, wrEvenParDir, conoApr200000}, 1'b0);
  checkBit("special flags", |{kernelCycle, pcPlus1Inh, pxct, intDisable, eboxHalted}, 1'b0);
  checkSr("sr", sr, '0);
  checkUcodeState("ucodeState", ucodeState, '0);
endtask

task automatic issueConsole(input diagFunc_e func);
  @(posedge CON_CLK);
  diagCtlEn <= 1'b1;
  diagSel   <= func;
  @(posedge CON_CLK);
  diagCtlEn <= 1'b0;
endtask

task automatic testResetState(input int cycles);
  logic [31:0] r;
  repeat (cycles) begin
    @(posedge CON_CLK);
    r = nextRandom();
    cond <= r[5:0];
    @(negedge CON_CLK);
    checkCondGroup("condEn", condEn, '0);
    checkRegsCleared();
  end
  @(posedge CON_CLK);
  arstN <= 1'b1;
  cond  <= '0;
  @(negedge CON_CLK);
  checkRegsCleared();
endtask

task automatic testCondDecode(input int count);
  logic [31:0] r;
  condField_t  c;
  condGroup_t  expEn;
  repeat (count) begin
    r = nextRandom();
    c = r[5:0];
    // Group 0x is the leftmost enable
    expEn = condGroup_t'(8'h80 >> c[0:2]);
    @(posedge CON_CLK);
    cond <= c;
    @(negedge CON_CLK);
    checkCondGroup("condEn", condEn, expEn);
    checkBit("loadIr", loadIr, (c[0:2] == 3'd1) && (c[3:5] == COND_LOAD_IR));
  end
  @(posedge CON_CLK);
  cond <= '0;
endtask

task automatic testConsoleRunStart();
  int cycles;
  @(negedge CON_CLK);
  checkBit("piDisable", piDisable, 1'b1);
  issueConsole(DIAG_SET_RUN);
  waitForLevel("run", 1'b1, cycles);
  checkLatency("run rise", cycles, SyncStages);
  checkBit("piDisable", piDisable, 1'b0);
  issueConsole(DIAG_CONTINUE);
  waitForLevel("start", 1'b1, cycles);
  checkLatency("start", cycles, SyncStages);
  @(negedge CON_CLK);
  checkBit("start", start, 1'b0);
  issueConsole(DIAG_CLR_RUN);
  waitForLevel("run", 1'b0, cycles);
  checkLatency("run fall", cycles, SyncStages);
  checkBit("piDisable", piDisable, 1'b1);
endtask

task automatic testIoFunctions();
  ebusWord_t pagData;
  ebusWord_t aprData;
  ebusWord_t piData;
  pagData = randomEbusWord();
  aprData = randomEbusWord();
  piData  = randomEbusWord();
  @(posedge CON_CLK);
  cond     <= {3'd2, COND_DIAG_FUNC};
  magic    <= {3'b000, FUNC_01X, IO_CONO_PAG};
  ebusData <= pagData;
  @(negedge CON_CLK);
  checkBit("conoPag", conoPag, 1'b1);
  checkBit("delayReq", delayReq, 1'b0);
  // Magic 04x is outside the I/O family and loads nothing
  @(posedge CON_CLK);
  magic    <= {3'b000, 3'b100, IO_CONO_PAG};
  ebusData <= ~pagData;
  @(negedge CON_CLK);
  checkBit("conoPag", conoPag, 1'b0);
  checkBit("delayReq", delayReq, 1'b1);
  checkBit("cacheLookEn", cacheLookEn, pagData[18]);
  checkBit("cacheLoadEn", cacheLoadEn, pagData[19]);
  checkBit("klPagingEn", klPagingEn, pagData[21]);
  checkBit("trapEn", trapEn, pagData[22]);
  @(posedge CON_CLK);
  ebusSync <= 1'b1;
  magic    <= {3'b000, FUNC_01X, IO_CONO_APR};
  ebusData <= aprData;
  @(negedge CON_CLK);
  checkBit("cacheLookEn", cacheLookEn, pagData[18]);
  checkBit("cacheLoadEn", cacheLoadEn, pagData[19]);
  checkBit("klPagingEn", klPagingEn, pagData[21]);
  checkBit("trapEn", trapEn, pagData[22]);
  checkBit("conoApr", conoApr, 1'b1);
  checkBit("selEn", selEn, aprData[20]);
  checkBit("selDis", selDis, aprData[21]);
  checkBit("selClr", selClr, aprData[22]);
  checkBit("selSet", selSet, aprData[23]);
  @(posedge CON_CLK);
  magic    <= {3'b000, FUNC_01X, IO_CONO_PI};
  ebusData <= piData;
  @(negedge CON_CLK);
  checkBit("conoApr200000", conoApr200000, aprData[19]);
  checkBit("conoApr", conoApr, 1'b0);
  checkBit("conoPi", conoPi, 1'b1);
  @(posedge CON_CLK);
  ebusSync <= 1'b0;
  magic    <= {3'b000, FUNC_01X, IO_DATAO_APR};
  @(negedge CON_CLK);
  checkBit("conoPi", conoPi, 1'b0);
  checkBit("dataoApr", dataoApr, 1'b1);
  checkBit("wrEvenParAdr", wrEvenParAdr, piData[18]);
  checkBit("wrEvenParData", wrEvenParData, piData[19]);
  checkBit("wrEvenParDir", wrEvenParDir, piData[20]);
  @(posedge CON_CLK);
  cond  <= '0;
  magic <= '0;
endtask

task automatic testSpecialState(input int count);
  logic [31:0] r;
  magicField_t m;
  magicField_t srMagic;
  ucodeState_t expState;
  r = nextRandom();
  m = r[8:0];
  // Bit 0 would start a PI cycle
  m[0] = 1'b0;
  r = nextRandom();
  srMagic = r[8:0];
  @(posedge CON_CLK);
  cond  <= {3'd1, COND_SPEC_INSTR};
  magic <= m;
  @(posedge CON_CLK);
  cond  <= {3'd1, COND_SR_MAGIC};
  magic <= srMagic;
  @(negedge CON_CLK);
  checkBit("kernelCycle", kernelCycle, m[1]);
  checkBit("pcPlus1Inh", pcPlus1Inh, m[2]);
  checkBit("pxct", pxct, m[4]);
  checkBit("intDisable", intDisable, m[5]);
  checkBit("eboxHalted", eboxHalted, m[7]);
  @(posedge CON_CLK);
  cond <= '0;
  @(negedge CON_CLK);
  checkSr("sr", sr, srMagic[5:8]);
  expState = '0;
  repeat (count) begin
    r = nextRandom();
    m = r[8:0];
    for (int k = 0; k < 4; k++) begin
      if (m[2*k+1]) begin
        expState[k] = 1'b1;
      end else if (!m[2*k+2]) begin
        expState[k] = 1'b0;
      end
    end
    @(posedge CON_CLK);
    cond  <= {3'd2, COND_EBOX_STATE};
    magic <= m;
    @(posedge CON_CLK);
    cond  <= '0;
    magic <= '0;
    @(negedge CON_CLK);
    checkUcodeState("ucodeState", ucodeState, expState);
  end
endtask

task automatic testCycles();
  @(posedge CON_CLK);
  mboxCycReq <= 1'b1;
  @(posedge CON_CLK);
  mboxCycReq <= 1'b0;
  mem        <= 4'b0010;
  vmaAcRef   <= 1'b1;
  vmaFetch   <= 1'b1;
  @(negedge CON_CLK);
  checkBit("memCycle", memCycle, 1'b1);
  checkBit("mboxWait", mboxWait, 1'b1);
  checkBit("fmXfer", fmXfer, 1'b1);
  checkBit("loadIr", loadIr, 1'b1);
  @(posedge CON_CLK);
  mem      <= '0;
  vmaAcRef <= 1'b0;
  vmaFetch <= 1'b0;
  @(negedge CON_CLK);
  checkBit("memCycle", memCycle, 1'b0);
  checkBit("mboxWait", mboxWait, 1'b0);
  @(posedge CON_CLK);
  cond  <= {3'd1, COND_SPEC_INSTR};
  magic <= 9'b1_0000_0000;
  @(posedge CON_CLK);
  cond  <= '0;
  magic <= '0;
  @(negedge CON_CLK);
  checkBit("piCycle", piCycle, 1'b1);
  @(posedge CON_CLK);
  skipSatisfied <= 1'b1;
  @(negedge CON_CLK);
  checkBit("piCycle", piCycle, 1'b1);
  @(posedge CON_CLK);
  skipSatisfied <= 1'b0;
  @(negedge CON_CLK);
  checkBit("piCycle", piCycle, 1'b0);
endtask

`endif

//--- test/conTb.sv
`timescale 1ns/10ps

module conTb import conPkg::*; ();

  localparam int SyncStages = 3;
  localparam int WaitLimit  = 20;

  logic        CON_CLK;
  logic        arstN;
  condField_t  cond;
  magicField_t magic;
  memField_t   mem;
  logic        diagCtlEn;
  diagFunc_e   diagSel;
  ebusWord_t   ebusData;
  logic        ebusSync;
  logic        dispNicond;
  logic        mboxCycReq;
  logic        vmaFetch;
  logic        vmaAcRef;
  logic        mbXfer;
  logic        pageError;
  logic        skipSatisfied;
  logic        saveFlags;
  logic        specFlagCtl;

  condGroup_t  condEn;
  logic        run;
  logic        start;
  logic        conoApr;
  logic        conoPi;
  logic        conoPag;
  logic        dataoApr;
  logic        conoApr200000;
  logic        selEn;
  logic        selDis;
  logic        selClr;
  logic        selSet;
  logic        delayReq;
  logic        cacheLookEn;
  logic        cacheLoadEn;
  logic        klPagingEn;
  logic        trapEn;
  logic        wrEvenParAdr;
  logic        wrEvenParData;
  logic        wrEvenParDir;
  logic        kernelCycle;
  logic        pcPlus1Inh;
  logic        pxct;
  logic        intDisable;
  logic        eboxHalted;
  logic        piDisable;
  srValue_t    sr;
  ucodeState_t ucodeState;
  logic        memCycle;
  logic        piCycle;
  logic        mboxWait;
  logic        fmXfer;
  logic        loadIr;

  logic [31:0] rngState;
  int          errorCount;
  int          timeoutCount;
  int          assertFails;

  conTop #(
    .RunSyncStages(SyncStages)
  ) i_conTop (.*);

  `include "conTbTasks.svh"

  initial begin
    CON_CLK = 1'b0;
    forever begin
      #2 CON_CLK = ~CON_CLK;
    end
  end

  initial begin
    rngState      = 32'h9cefb715;
    errorCount    = 0;
    timeoutCount  = 0;
    arstN         = 1'b0;
    cond          = '0;
    magic         = '0;
    mem           = '0;
    diagCtlEn     = 1'b0;
    diagSel       = DIAG_CLR_RUN;
    ebusData      = '0;
    ebusSync      = 1'b0;
    dispNicond    = 1'b0;
    mboxCycReq    = 1'b0;
    vmaFetch      = 1'b0;
    vmaAcRef      = 1'b0;
    mbXfer        = 1'b0;
    pageError     = 1'b0;
    skipSatisfied = 1'b0;
    saveFlags     = 1'b0;
    specFlagCtl   = 1'b0;

    testResetState(8);
    testCondDecode(24);
    testConsoleRunStart();
    testIoFunctions();
    testSpecialState(8);
    testCycles();

    repeat (2) @(posedge CON_CLK);
    assertFails = i_conTop.i_conTopProperties.failCount;
    $display("Value errors: %0d, timeouts: %0d, assertion failures: %0d",
             errorCount, timeoutCount, assertFails);
    if (errorCount == 0 && timeoutCount == 0 && assertFails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+include
verilog/conPkg.sv
verilog/condDecoder.sv
verilog/consoleRunCtl.sv
verilog/ioFuncDecoder.sv
verilog/specInstrState.sv
verilog/cycleTracker.sv
verilog/conTop.sv
test/conTop_properties.sv
test/conTb.sv

//--- Bender.yml
package:
  name: con_board

sources:
  - verilog/conPkg.sv
  - verilog/condDecoder.sv
  - verilog/consoleRunCtl.sv
  - verilog/ioFuncDecoder.sv
  - verilog/specInstrState.sv
  - verilog/cycleTracker.sv
  - verilog/conTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/conTop_properties.sv
      - test/conTb.sv
